// ==== rtl/nes_dma_settings.svh ====
`ifndef NES_DMA_SETTINGS_SVH
`define NES_DMA_SETTINGS_SVH

// Master clock ratio
// One CPU cycle spans this many master clocks (NTSC 2A03)
`define CPU_DIV 12

// CPU bus widths
`define ADDR_W 16 // 64K CPU address space
`define DATA_W 8  // Byte wide data bus

// Register map seen by the DMA controller
// Writing a page number here starts sprite DMA
`define OAM_DMA_REG 16'h4014

// PPU sprite data port, target of every sprite DMA write
`define OAM_DATA_REG 16'h2004

`endif

// ==== rtl/nes_dma_pkg.sv ====
`include "nes_dma_settings.svh"

package nes_dma_pkg;

	// CPU side bus types
	typedef logic [`ADDR_W-1:0] nes_addr_t; // Full CPU address
	typedef logic [`DATA_W-1:0] nes_data_t; // One data byte

	// Sprite engine FSM
	typedef enum logic [1:0] {
		SPR_IDLE, // Nothing to do
		SPR_WAIT, // Triggered, waiting for a free get cycle
		SPR_RUN   // Alternating reads and writes
	} spr_state_t;

	// DMC engine FSM
	typedef enum logic {
		DMC_IDLE, // No fetch pending
		DMC_WAIT  // Fetch accepted, read on the next get cycle
	} dmc_state_t;

	// Current bus master
	typedef enum logic [1:0] {
		OWN_CPU,    // Default when no DMA grant
		OWN_SPRITE, // Sprite engine read or write
		OWN_DMC     // DMC sample fetch
	} bus_owner_t;

endpackage

// ==== rtl/dma_bus_if.sv ====
`timescale 1ns/1ps

// Request and grant link between one DMA engine and the arbiter
interface dma_bus_if
	import nes_dma_pkg::*;
();

	logic      req;   // Engine wants the bus this CPU cycle
	nes_addr_t addr;  // Target address
	logic      write; // 1 for write, 0 for read
	nes_data_t wdata; // Byte to write
	logic      grant; // Arbiter hands over the bus

	// Engine drives the request fields and holds them until served
	modport engine (
		output req,
		output addr,
		output write,
		output wdata,
		input  grant
	);

	// Arbiter looks at requests and answers with grant
	modport arbiter (
		input  req,
		input  addr,
		input  write,
		input  wdata,
		output grant
	);

endinterface

// ==== rtl/cpu_clock_divider.sv ====
`timescale 1ns/1ps
`include "nes_dma_settings.svh"

// Master clock divider for the CPU enable and the get/put phase
module cpu_clock_divider (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clk pulse per CPU cycle
	output logic put_phase, // 1 on put (odd) cycles, 0 on get (even) cycles
	output logic get_ce,    // CPU enable in a get cycle
	output logic put_ce     // CPU enable in a put cycle
);

	logic [4:0] div_cnt;  // Master clocks into the current CPU cycle
	logic       div_last; // Last master clock of the CPU cycle

	assign div_last = (div_cnt == 5'(`CPU_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= '0;
			cpu_ce    <= 1'b0;
			put_phase <= 1'b1; // First CPU cycle after reset is a put
		end else begin
			div_cnt <= div_last ? 5'd0 : div_cnt + 5'd1;
			cpu_ce  <= div_last; // Registered, so the first pulse lands 12 clocks out

			// Phase flips at the end of every CPU cycle
			if (cpu_ce)
				put_phase <= ~put_phase;
		end
	end

	// Phased enables
	assign get_ce = cpu_ce & ~put_phase;
	assign put_ce = cpu_ce & put_phase;

endmodule

// ==== rtl/sprite_dma.sv ====
`timescale 1ns/1ps
`include "nes_dma_settings.svh"

// Sprite page DMA
// Copies 256 bytes from page xx00-xxFF to the PPU sprite data port
module sprite_dma
	import nes_dma_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          get_ce,
	input  logic          put_ce,
	input  nes_addr_t     cpu_addr,
	input  logic          cpu_write,
	input  nes_data_t     cpu_wdata,
	input  nes_data_t     mem_rdata,
	dma_bus_if.engine     bus,
	output logic          busy      // Asks the arbiter to hold the CPU
);

	spr_state_t state;
	nes_data_t  page;      // Source page, high address byte
	nes_data_t  idx;       // Byte within the page
	nes_data_t  byte_q;    // Byte read, waiting for its write
	logic       have_byte; // Next access is the write half of the pair
	logic       trig;      // CPU writes the sprite page register
	logic       rd_done;   // Granted read on a get cycle
	logic       wr_done;   // Granted write on a put cycle
	logic       lost_get;  // DMC took the get cycle we needed

	// Decode the page register write
	assign trig = (get_ce | put_ce) & cpu_write & (cpu_addr == `OAM_DMA_REG);

	// Request fields, stable for the whole CPU cycle
	assign bus.req   = (state == SPR_RUN);
	assign bus.write = have_byte;
	assign bus.addr  = have_byte ? nes_addr_t'(`OAM_DATA_REG) : {page, idx};
	assign bus.wdata = byte_q;

	assign rd_done  = bus.req & bus.grant & ~have_byte & get_ce;
	assign wr_done  = bus.req & bus.grant & have_byte & put_ce;
	assign lost_get = bus.req & ~bus.grant & ~have_byte & get_ce;

	assign busy = (state != SPR_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= SPR_IDLE;
			idx       <= '0;
			have_byte <= 1'b0;
		end else begin
			case (state)
				SPR_IDLE: begin
					if (trig) begin
						state     <= SPR_WAIT;
						idx       <= '0; // Always start at xx00
						have_byte <= 1'b0;
					end
				end
				SPR_WAIT: begin
					// Halt point, CPU must be in a read cycle
					if (get_ce && !cpu_write)
						state <= SPR_RUN;
				end
				SPR_RUN: begin
					if (rd_done)
						have_byte <= 1'b1;
					else if (lost_get)
						state <= SPR_WAIT; // Same index is read again later
					if (wr_done) begin
						have_byte <= 1'b0;
						idx       <= idx + 8'd1;
						if (idx == 8'hFF)
							state <= SPR_IDLE; // Whole page copied
					end
				end
				default: state <= SPR_IDLE;
			endcase
		end
	end

	// Page and byte latches
	always_ff @(posedge clk) begin
		if (state == SPR_IDLE && trig)
			page <= cpu_wdata; // Value written selects the source page
		if (rd_done)
			byte_q <= mem_rdata;
	end

endmodule

// ==== rtl/dmc_dma.sv ====
`timescale 1ns/1ps

// DMC sample fetch, one byte per request
module dmc_dma
	import nes_dma_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      get_ce,
	input  logic      put_ce,
	input  logic      cpu_write,
	input  logic      dmc_req,   // Audio unit wants a sample byte
	input  nes_addr_t dmc_addr,  // Sample address, valid with dmc_req
	input  nes_data_t mem_rdata,
	dma_bus_if.engine bus,
	output logic      dmc_ack,   // One clk, in the read cycle
	output nes_data_t dmc_data,
	output logic      waiting    // Fetch accepted, not yet served
);

	dmc_state_t state;
	nes_data_t  byte_q; // Last fetched sample byte

	assign waiting = (state == DMC_WAIT);

	// Read only request
	assign bus.req   = waiting;
	assign bus.addr  = dmc_addr;
	assign bus.write = 1'b0;
	assign bus.wdata = '0;

	assign dmc_ack = waiting & bus.grant & get_ce;

	// Live byte during the ack, held byte afterwards
	assign dmc_data = dmc_ack ? mem_rdata : byte_q;

	always_ff @(posedge clk) begin
		if (reset)
			state <= DMC_IDLE;
		else if (state == DMC_IDLE && dmc_req && put_ce && !cpu_write)
			state <= DMC_WAIT; // Accepted on a put, CPU halted in a read
		else if (dmc_ack)
			state <= DMC_IDLE;
	end

	always_ff @(posedge clk) begin
		if (dmc_ack)
			byte_q <= mem_rdata;
	end

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

// Shares the CPU side memory bus among DMC, sprite DMA and the CPU
module bus_arbiter
	import nes_dma_pkg::*;
(
	input  logic       put_phase,
	dma_bus_if.arbiter spr,
	dma_bus_if.arbiter dmc,
	input  logic       spr_busy,    // Sprite engine triggered or running
	input  logic       dmc_req,     // Raw DMC request
	input  logic       dmc_waiting, // DMC fetch accepted
	input  nes_addr_t  cpu_addr,
	input  logic       cpu_write,
	input  nes_data_t  cpu_wdata,
	output nes_addr_t  mem_addr,
	output logic       mem_read,
	output logic       mem_write,
	output nes_data_t  mem_wdata,
	output bus_owner_t owner,
	output logic       pause_cpu
);

	logic dmc_phase_ok; // DMC access fits the current phase
	logic spr_phase_ok; // Sprite access fits the current phase

	// Reads on get cycles, writes on put cycles
	assign dmc_phase_ok = dmc.write ? put_phase : ~put_phase;
	assign spr_phase_ok = spr.write ? put_phase : ~put_phase;

	// Fixed priority, DMC over sprite
	assign dmc.grant = dmc.req & dmc_phase_ok;
	assign spr.grant = spr.req & spr_phase_ok & ~dmc.grant;

	always_comb begin
		if (dmc.grant)
			owner = OWN_DMC;
		else if (spr.grant)
			owner = OWN_SPRITE;
		else
			owner = OWN_CPU;
	end

	// Bus mux
	always_comb begin
		case (owner)
			OWN_DMC: begin
				mem_addr  = dmc.addr;
				mem_write = dmc.write;
				mem_wdata = dmc.wdata;
			end
			OWN_SPRITE: begin
				mem_addr  = spr.addr;
				mem_write = spr.write;
				mem_wdata = spr.wdata;
			end
			default: begin
				mem_addr  = cpu_addr; // CPU passes straight through
				mem_write = cpu_write;
				mem_wdata = cpu_wdata;
			end
		endcase
		mem_read = ~mem_write; // Bus is always either reading or writing
	end

	// Hold the CPU while any DMA is pending or active
	assign pause_cpu = spr_busy | dmc_req | dmc_waiting;

endmodule

// ==== rtl/nes_dma_top.sv ====
`timescale 1ns/1ps

// 2A03 DMA controller with its shared CPU side bus
module nes_dma_top
	import nes_dma_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  nes_addr_t  cpu_addr,
	input  logic       cpu_write,
	input  nes_data_t  cpu_wdata,
	input  logic       dmc_req,
	input  nes_addr_t  dmc_addr,
	input  nes_data_t  mem_rdata, // Combinational memory response
	output nes_addr_t  mem_addr,
	output logic       mem_read,
	output logic       mem_write,
	output nes_data_t  mem_wdata,
	output bus_owner_t owner,
	output logic       pause_cpu,
	output logic       dmc_ack,
	output nes_data_t  dmc_data,
	output logic       cpu_ce
);

	logic put_phase;   // Current CPU cycle is a put
	logic get_ce;      // CPU enable, get cycle
	logic put_ce;      // CPU enable, put cycle
	logic spr_busy;    // Sprite engine holds the CPU
	logic dmc_waiting; // DMC fetch pending

	dma_bus_if spr_bus ();
	dma_bus_if dmc_bus ();

	cpu_clock_divider u_cpu_clock_divider (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.put_phase (put_phase),
		.get_ce    (get_ce),
		.put_ce    (put_ce)
	);

	sprite_dma u_sprite_dma (
		.clk       (clk),
		.reset     (reset),
		.get_ce    (get_ce),
		.put_ce    (put_ce),
		.cpu_addr  (cpu_addr),
		.cpu_write (cpu_write),
		.cpu_wdata (cpu_wdata),
		.mem_rdata (mem_rdata),
		.bus       (spr_bus.engine),
		.busy      (spr_busy)
	);

	dmc_dma u_dmc_dma (
		.clk       (clk),
		.reset     (reset),
		.get_ce    (get_ce),
		.put_ce    (put_ce),
		.cpu_write (cpu_write),
		.dmc_req   (dmc_req),
		.dmc_addr  (dmc_addr),
		.mem_rdata (mem_rdata),
		.bus       (dmc_bus.engine),
		.dmc_ack   (dmc_ack),
		.dmc_data  (dmc_data),
		.waiting   (dmc_waiting)
	);

	bus_arbiter u_bus_arbiter (
		.put_phase   (put_phase),
		.spr         (spr_bus.arbiter),
		.dmc         (dmc_bus.arbiter),
		.spr_busy    (spr_busy),
		.dmc_req     (dmc_req),
		.dmc_waiting (dmc_waiting),
		.cpu_addr    (cpu_addr),
		.cpu_write   (cpu_write),
		.cpu_wdata   (cpu_wdata),
		.mem_addr    (mem_addr),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_wdata   (mem_wdata),
		.owner       (owner),
		.pause_cpu   (pause_cpu)
	);

endmodule

// ==== testbench/tb_nes_dma.sv ====
`timescale 1ns/1ps
`include "nes_dma_settings.svh"

// Random-stimulus testbench for the 2A03 DMA controller
module tb_nes_dma
	import nes_dma_pkg::*;
();

	localparam int RUNS    = 20;  // Sprite DMA runs
	localparam int RUN_CYC = 520; // CPU cycles budgeted per run
	localparam int TIMEOUT = RUNS * RUN_CYC * `CPU_DIV * 3 / 2 + 2000 * `CPU_DIV;

	logic       clk;
	logic       reset;
	nes_addr_t  cpu_addr;
	logic       cpu_write;
	nes_data_t  cpu_wdata;
	logic       dmc_req;
	nes_addr_t  dmc_addr;
	nes_data_t  mem_rdata;
	nes_addr_t  mem_addr;
	logic       mem_read;
	logic       mem_write;
	nes_data_t  mem_wdata;
	bus_owner_t owner;
	logic       pause_cpu;
	logic       dmc_ack;
	nes_data_t  dmc_data;
	logic       cpu_ce;

	integer    seed;
	int        errors, checks, cycles;
	int        runs_done, dmc_reqs, dmc_acks;
	int        ce_clks;              // Clocks since reset fell
	logic      ce_s, pause_s, ack_s; // DUT outputs taken at the falling edge
	logic      trig_pending;         // Test asks the CPU for a sprite page write
	nes_data_t trig_page;
	logic      after_trig;           // Cycle after the page write is a read
	logic      dmc_en;               // New DMC requests allowed
	int        dmc_gap;              // CPU cycles until the next DMC request
	logic      spr_active;           // Sprite transfer expected
	nes_data_t spr_page;
	int        spr_count;            // Writes seen in this run
	logic      spr_have;             // Read done, write of the same index due

	nes_dma_top u_nes_dma_top (
		.clk       (clk),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpu_write (cpu_write),
		.cpu_wdata (cpu_wdata),
		.dmc_req   (dmc_req),
		.dmc_addr  (dmc_addr),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_wdata (mem_wdata),
		.owner     (owner),
		.pause_cpu (pause_cpu),
		.dmc_ack   (dmc_ack),
		.dmc_data  (dmc_data),
		.cpu_ce    (cpu_ce)
	);

	// Memory contents, a function of the whole address
	function automatic nes_data_t mem_byte(input nes_addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	assign mem_rdata = mem_byte(mem_addr); // Combinational memory

	// Random CPU address that never hits the sprite page register
	function automatic nes_addr_t rand_cpu_addr();
		nes_addr_t a;
		a = nes_addr_t'($random(seed));
		if (a == `OAM_DMA_REG)
			a = 16'h0000;
		return a;
	endfunction

	task automatic check_addr(input string name, input nes_addr_t got, input nes_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input nes_data_t got, input nes_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_owner(input string name, input bus_owner_t got, input bus_owner_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	// One CPU cycle on the shared bus, called at the falling edge with cpu_ce high
	task automatic check_bus_cycle();
		nes_addr_t src;
		src = {spr_page, spr_count[7:0]}; // Source of the next sprite byte
		if (spr_active) begin
			check_bit("pause_cpu", pause_cpu, 1'b1);
		end else if (!dmc_req) begin
			check_owner("owner", owner, OWN_CPU); // No DMA pending
			check_bit("pause_cpu", pause_cpu, 1'b0);
		end
		case (owner)
			OWN_CPU: begin
				check_addr("mem_addr", mem_addr, cpu_addr);
				check_bit("mem_write", mem_write, cpu_write);
				check_data("mem_wdata", mem_wdata, cpu_wdata);
				check_bit("mem_read", mem_read, !cpu_write);
			end
			OWN_DMC: begin
				dmc_acks++;
				check_bit("dmc_ack", dmc_ack, 1'b1);
				check_bit("mem_read", mem_read, 1'b1);
				check_addr("mem_addr", mem_addr, dmc_addr);
				check_data("dmc_data", dmc_data, mem_byte(dmc_addr));
			end
			OWN_SPRITE: begin
				if (!spr_active) begin
					report_error("sprite engine took the bus without a page write");
				end else if (!mem_write) begin
					if (spr_have)
						report_error("sprite engine read twice for one index");
					check_addr("mem_addr", mem_addr, src);
					spr_have = 1'b1;
				end else begin
					if (!spr_have)
						report_error("sprite engine wrote without reading first");
					check_addr("mem_addr", mem_addr, `OAM_DATA_REG);
					check_data("mem_wdata", mem_wdata, mem_byte(src));
					spr_have = 1'b0;
					spr_count++;
					if (spr_count == 256) begin
						spr_active = 1'b0; // Whole page seen
						runs_done++;
					end
				end
			end
			default: report_error("bus owner has no legal value");
		endcase
		// CPU writes the page register, a new run starts
		if (!spr_active && owner == OWN_CPU && cpu_write && cpu_addr == `OAM_DMA_REG) begin
			spr_active = 1'b1;
			spr_page   = cpu_wdata;
			spr_count  = 0;
			spr_have   = 1'b0;
		end
	endtask

	task automatic wait_cpu_cycles(input int n);
		int k;
		k = 0;
		while (k < n) begin
			@(posedge clk);
			if (ce_s)
				k++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Monitor at the falling edge, where all outputs have settled
	always @(negedge clk) begin
		ce_s    = cpu_ce;
		pause_s = pause_cpu;
		ack_s   = dmc_ack;
		if (reset) begin
			ce_clks = 0;
		end else begin
			// One enable every CPU_DIV clocks, the first CPU_DIV clocks after reset
			check_bit("cpu_ce", cpu_ce, ce_clks != 0 && ce_clks % `CPU_DIV == 0);
			ce_clks++;
			if (dmc_ack && !dmc_req)
				report_error("dmc_ack without a pending DMC request");
			if (cpu_ce)
				check_bus_cycle();
		end
	end

	// CPU and DMC request models, both advance at the CPU enable
	always @(posedge clk) begin
		if (ce_s && (!pause_s || cpu_write)) begin // A halted 6502 only stops on a read
			if (trig_pending && !pause_s && !after_trig) begin
				cpu_addr     <= `OAM_DMA_REG;
				cpu_write    <= 1'b1;
				cpu_wdata    <= trig_page;
				trig_pending <= 1'b0;
				after_trig   <= 1'b1;
			end else begin
				cpu_addr   <= rand_cpu_addr();
				cpu_wdata  <= nes_data_t'($random(seed));
				cpu_write  <= !pause_s && !after_trig && (($random(seed) & 3) == 0);
				after_trig <= 1'b0;
			end
		end
		if (dmc_req) begin
			if (ack_s) begin
				dmc_req <= 1'b0; // Served
				dmc_gap <= ($random(seed) & 255) + 4;
			end
		end else if (dmc_en && ce_s) begin
			if (dmc_gap == 0) begin
				dmc_req  <= 1'b1;
				dmc_addr <= nes_addr_t'($random(seed));
				dmc_reqs <= dmc_reqs + 1;
			end else begin
				dmc_gap <= dmc_gap - 1;
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("ERROR: timeout after %0d clocks, a DMA transfer never finished", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int pause_gap;
		seed         = 25805;
		reset        = 1'b1;
		cpu_addr     = '0;
		cpu_write    = 1'b0;
		cpu_wdata    = '0;
		dmc_req      = 1'b0;
		dmc_addr     = '0;
		errors       = 0;
		checks       = 0;
		cycles       = 0;
		runs_done    = 0;
		dmc_reqs     = 0;
		dmc_acks     = 0;
		ce_clks      = 0;
		ce_s         = 1'b0;
		pause_s      = 1'b0;
		ack_s        = 1'b0;
		trig_pending = 1'b0;
		trig_page    = '0;
		after_trig   = 1'b0;
		dmc_en       = 1'b0;
		dmc_gap      = 10;
		spr_active   = 1'b0;
		spr_page     = '0;
		spr_count    = 0;
		spr_have     = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit("pause_cpu", pause_cpu, 1'b0); // State right after reset
		check_bit("dmc_ack", dmc_ack, 1'b0);
		check_bit("mem_write", mem_write, 1'b0);
		check_owner("owner", owner, OWN_CPU);
		wait_cpu_cycles(40); // Plain CPU traffic
		@(negedge clk);
		dmc_en = 1'b1;
		for (int r = 0; r < RUNS; r++) begin
			@(negedge clk);
			trig_page    = nes_data_t'($random(seed));
			pause_gap    = ($random(seed) & 63) + 2;
			trig_pending = 1'b1;
			while (runs_done == r)
				@(posedge clk);
			wait_cpu_cycles(pause_gap);
		end
		@(negedge clk);
		dmc_en = 1'b0;
		while (dmc_req)
			@(posedge clk);
		wait_cpu_cycles(40);
		@(negedge clk);
		if (dmc_acks != dmc_reqs)
			report_error("number of DMC acks differs from number of DMC requests");
		$display("Errors: %0d  checks: %0d  sprite runs: %0d  dmc requests: %0d  dmc acks: %0d",
			errors, checks, runs_done, dmc_reqs, dmc_acks);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/nes_dma_pkg.sv
rtl/dma_bus_if.sv
rtl/cpu_clock_divider.sv
rtl/sprite_dma.sv
rtl/dmc_dma.sv
rtl/bus_arbiter.sv
rtl/nes_dma_top.sv
testbench/tb_nes_dma.sv
